/* design/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS    = 4;
    localparam int LINE_WORDS  = 4;   // 32-bit words per line
    localparam int OFFSET_BITS = 4;   // byte offset inside a 16-byte line

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        REFILL,
        WRITE_LINE,
        REPLY
    } cache_state_e;

    // sized to the 7-bit exception port toward the core
    typedef enum logic [6:0] {
        EXC_NONE        = 7'h00,
        EXC_PC_MISALIGN = 7'h01
    } exc_code_e;

    typedef logic [NUM_WAYS-1:0] way_mask_t;         // one-hot or zero
    typedef logic [LINE_WORDS*32-1:0] line_t;        // word 0 in the low bits

endpackage

`default_nettype wire

/* design/icache_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid,
    input  logic [1:0]            pc_low,
    input  icache_pkg::way_mask_t way_hit,
    input  logic                  fill_done,
    input  icache_pkg::way_mask_t victim_q,
    input  logic                  r_rdy,
    output logic                  ready,
    output logic                  rbuf_we,
    output logic                  mbuf_we,
    output logic                  lru_touch,
    output logic                  data_valid,
    output logic                  r_req,
    output logic                  r_data_ready,
    output icache_pkg::way_mask_t touch_way,
    output icache_pkg::way_mask_t tagv_we,
    output icache_pkg::way_mask_t mem_we,
    output icache_pkg::exc_code_e exception
);
    import icache_pkg::*;

    cache_state_e state;
    cache_state_e state_nxt;
    logic         misalign;
    logic         hit;

    assign misalign  = (pc_low != 2'b00);    // from the buffered pc
    assign hit       = |way_hit;
    assign exception = misalign ? EXC_PC_MISALIGN : EXC_NONE;   // held with the buffer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt    = state;
        ready        = 1'b0;
        rbuf_we      = 1'b0;
        mbuf_we      = 1'b0;
        lru_touch    = 1'b0;
        data_valid   = 1'b0;
        r_req        = 1'b0;
        r_data_ready = 1'b0;
        touch_way    = '0;
        tagv_we      = '0;
        mem_we       = '0;
        case (state)
            IDLE: begin
                ready   = 1'b1;
                rbuf_we = valid;                  // accept and start the array read
                if (valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (misalign) begin
                    data_valid = 1'b1;            // answered without a lookup
                    state_nxt  = IDLE;
                end else if (hit) begin
                    data_valid = 1'b1;
                    lru_touch  = 1'b1;
                    touch_way  = way_hit;
                    state_nxt  = IDLE;
                end else begin
                    mbuf_we   = 1'b1;             // keep the lru victim for the refill
                    state_nxt = MISS_REQ;
                end
            end
            MISS_REQ: begin
                r_req = 1'b1;
                if (r_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                r_data_ready = 1'b1;
                if (fill_done) begin
                    state_nxt = WRITE_LINE;
                end
            end
            WRITE_LINE: begin
                tagv_we   = victim_q;
                mem_we    = victim_q;
                lru_touch = 1'b1;
                touch_way = victim_q;
                state_nxt = REPLY;
            end
            REPLY: begin
                data_valid = 1'b1;                // data comes from the fill line
                state_nxt  = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // the refill writes exactly one way of the set
    a_one_way_write: assert property (@(posedge clk) disable iff (!rst_n)
        (state == WRITE_LINE) |-> $onehot(victim_q));

endmodule

`default_nettype wire

/* design/refill_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  logic [31:0]       r_data_axi,
    output logic              fill_done,
    output icache_pkg::line_t line
);
    import icache_pkg::*;

    localparam int CNT_W = $clog2(LINE_WORDS);

    logic [CNT_W-1:0] beat_cnt;       // word slot of the next beat

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= ret_valid && ret_last;      // line register complete now
            if (ret_valid) begin
                if (ret_last) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // beats come in ascending order from the line base
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            line[beat_cnt*32 +: 32] <= r_data_axi;
        end
    end

    // the bus always returns a full line in one burst
    a_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
        (ret_valid && ret_last) |-> (beat_cnt == CNT_W'(LINE_WORDS - 1)));

endmodule

`default_nettype wire

/* design/tagv_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tagv_store #(
    parameter int NUM_SETS = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           r_addr,
    input  logic [31:0]           w_addr,
    input  icache_pkg::way_mask_t we,
    output icache_pkg::way_mask_t way_hit
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - OFFSET_BITS - IDX_W;

    logic [TAG_W-1:0]    tag_mem    [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
    logic [TAG_W-1:0]    tag_rd     [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_rd;
    logic [TAG_W-1:0]    tag_q;                 // tag of the address being read
    logic [IDX_W-1:0]    r_idx;
    logic [IDX_W-1:0]    w_idx;
    logic [TAG_W-1:0]    w_tag;

    assign r_idx = r_addr[OFFSET_BITS +: IDX_W];
    assign w_idx = w_addr[OFFSET_BITS +: IDX_W];
    assign w_tag = w_addr[31 -: TAG_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '{default: '0};
            valid_rd   <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_rd[w] <= valid_bits[w][r_idx];
                if (we[w]) begin
                    valid_bits[w][w_idx] <= 1'b1;
                end
            end
        end
    end

    // read returns the old tag when the same set is written
    always_ff @(posedge clk) begin
        tag_q <= r_addr[31 -: TAG_W];
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_rd[w] <= tag_mem[w][r_idx];
            if (we[w]) begin
                tag_mem[w][w_idx] <= w_tag;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_rd[w] && (tag_rd[w] == tag_q);
        end
    end

    // refills only go to lines that missed, so a tag never sits in two ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit));

endmodule

`default_nettype wire

/* design/data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module data_store #(
    parameter int NUM_SETS = 16
) (
    input  logic                  clk,
    input  logic [31:0]           r_addr,
    input  logic [31:0]           w_addr,
    input  icache_pkg::line_t     line_in,
    input  icache_pkg::way_mask_t we,
    input  icache_pkg::way_mask_t way_hit,
    input  logic                  fill_sel,
    input  icache_pkg::line_t     fill_line,
    output logic [63:0]           r_data
);
    import icache_pkg::*;

    localparam int IDX_W       = $clog2(NUM_SETS);
    localparam int DW_PER_LINE = LINE_WORDS / 2;
    localparam int DW_W        = $clog2(DW_PER_LINE);

    line_t            line_mem [NUM_WAYS][NUM_SETS];
    line_t            line_rd  [NUM_WAYS];
    line_t            line_sel;
    logic [DW_W-1:0]  dw_q;                    // doubleword inside the line
    logic [IDX_W-1:0] r_idx;
    logic [IDX_W-1:0] w_idx;

    assign r_idx = r_addr[OFFSET_BITS +: IDX_W];
    assign w_idx = w_addr[OFFSET_BITS +: IDX_W];

    always_ff @(posedge clk) begin
        dw_q <= r_addr[OFFSET_BITS-1 -: DW_W];
        for (int w = 0; w < NUM_WAYS; w++) begin
            line_rd[w] <= line_mem[w][r_idx];
            if (we[w]) begin
                line_mem[w][w_idx] <= line_in;
            end
        end
    end

    always_comb begin
        line_sel = '0;
        if (fill_sel) begin
            line_sel = fill_line;               // bypass right after a refill
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (way_hit[w]) begin
                    line_sel = line_rd[w];
                end
            end
        end
    end

    assign r_data = line_sel[dw_q*64 +: 64];

endmodule

`default_nettype wire

/* design/lru_select.sv */
`timescale 1ns/1ps
`default_nettype none

module lru_select #(
    parameter int NUM_SETS = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           index_addr,
    input  logic                  touch,
    input  icache_pkg::way_mask_t touch_way,
    output icache_pkg::way_mask_t victim
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int AGE_W = $clog2(NUM_WAYS);

    logic [AGE_W-1:0] age [NUM_SETS][NUM_WAYS];   // 0 is most recent
    logic [IDX_W-1:0] idx;
    logic [AGE_W-1:0] touch_age;

    assign idx = index_addr[OFFSET_BITS +: IDX_W];

    always_comb begin
        touch_age = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (touch_way[w]) begin
                touch_age = age[idx][w];
            end
        end
    end

    // ages stay a permutation, so exactly one way is oldest
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            victim[w] = (age[idx][w] == AGE_W'(NUM_WAYS - 1));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age[s][w] <= AGE_W'(w);         // way 3 goes first
                end
            end
        end else if (touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (touch_way[w]) begin
                    age[idx][w] <= '0;
                end else if (age[idx][w] < touch_age) begin
                    age[idx][w] <= age[idx][w] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int COOKIE_WIDTH = 32,
    parameter int NUM_SETS     = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // cpu fetch side
    input  logic                    valid,
    input  logic [31:0]             pc_in,
    input  logic [COOKIE_WIDTH-1:0] cookie_in,
    output logic                    ready,
    output logic                    data_valid,
    output logic [63:0]             r_data,
    output logic [31:0]             pc_out,
    output logic [COOKIE_WIDTH-1:0] cookie_out,
    output icache_pkg::exc_code_e   exception,
    // line refill bus
    output logic                    r_req,
    output logic [31:0]             r_addr,
    output logic                    r_data_ready,
    input  logic                    r_rdy,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  logic [31:0]             r_data_axi
);
    import icache_pkg::*;

    logic [31:0]             pc_q;
    logic [COOKIE_WIDTH-1:0] cookie_q;
    logic [31:0]             rd_addr;
    logic                    rbuf_we;
    logic                    mbuf_we;
    logic                    lru_touch;
    logic                    fill_done;
    logic                    fill_sel;
    logic [63:0]             store_data;
    way_mask_t               way_hit;
    way_mask_t               victim;
    way_mask_t               victim_q;
    way_mask_t               touch_way;
    way_mask_t               tagv_we;
    way_mask_t               mem_we;
    line_t                   fill_line;

    // request buffer held until the next acceptance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q     <= '0;
            cookie_q <= '0;
        end else if (rbuf_we) begin
            pc_q     <= pc_in;
            cookie_q <= cookie_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= '0;
        end else if (mbuf_we) begin
            victim_q <= victim;                 // way to refill
        end
    end

    assign rd_addr    = rbuf_we ? pc_in : pc_q;   // re-read keeps r_data stable
    assign r_addr     = {pc_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign pc_out     = pc_q;
    assign cookie_out = cookie_q;
    assign fill_sel   = ~(|way_hit);            // reply cycle reads the old set
    assign r_data     = (exception != EXC_NONE) ? 64'd0 : store_data;

    icache_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .valid(valid), .pc_low(pc_q[1:0]),
        .way_hit(way_hit), .fill_done(fill_done), .victim_q(victim_q), .r_rdy(r_rdy),
        .ready(ready), .rbuf_we(rbuf_we), .mbuf_we(mbuf_we), .lru_touch(lru_touch),
        .data_valid(data_valid), .r_req(r_req), .r_data_ready(r_data_ready),
        .touch_way(touch_way), .tagv_we(tagv_we), .mem_we(mem_we), .exception(exception)
    );

    refill_buffer u_refill (
        .clk(clk), .rst_n(rst_n), .ret_valid(ret_valid), .ret_last(ret_last),
        .r_data_axi(r_data_axi), .fill_done(fill_done), .line(fill_line)
    );

    tagv_store #(.NUM_SETS(NUM_SETS)) u_tagv (
        .clk(clk), .rst_n(rst_n), .r_addr(rd_addr), .w_addr(pc_q),
        .we(tagv_we), .way_hit(way_hit)
    );

    data_store #(.NUM_SETS(NUM_SETS)) u_data (
        .clk(clk), .r_addr(rd_addr), .w_addr(pc_q), .line_in(fill_line), .we(mem_we),
        .way_hit(way_hit), .fill_sel(fill_sel), .fill_line(fill_line), .r_data(store_data)
    );

    lru_select #(.NUM_SETS(NUM_SETS)) u_lru (
        .clk(clk), .rst_n(rst_n), .index_addr(pc_q), .touch(lru_touch),
        .touch_way(touch_way), .victim(victim)
    );

endmodule

`default_nettype wire

/* verif/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int COOKIE_W     = 32;
    localparam int SETS         = 16;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_PATS     = 64;
    localparam int CYCLES_PER   = 40;       // cycles allowed per fetch

    logic                clk;
    logic                rst_n;
    logic                valid;
    logic [31:0]         pc_in;
    logic [COOKIE_W-1:0] cookie_in;
    logic                ready;
    logic                data_valid;
    logic [63:0]         r_data;
    logic [31:0]         pc_out;
    logic [COOKIE_W-1:0] cookie_out;
    exc_code_e           exception;
    logic                r_req;
    logic [31:0]         r_addr;
    logic                r_data_ready;
    logic                r_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [31:0]         r_data_axi;

    logic [71:0]  pat_mem [MAX_PATS];       // pc, cookie, kind
    int           num_pats;
    int           cycle = 0;
    int           timeout_limit = 0;
    integer       seed = 32'h4a53_f5d4;
    cache_state_e fsm_state;

    assign fsm_state = DUT.u_fsm.state;     // only for the timeout message

    icache #(.COOKIE_WIDTH(COOKIE_W), .NUM_SETS(SETS)) DUT (
        .clk(clk), .rst_n(rst_n), .valid(valid), .pc_in(pc_in), .cookie_in(cookie_in),
        .ready(ready), .data_valid(data_valid), .r_data(r_data), .pc_out(pc_out),
        .cookie_out(cookie_out), .exception(exception), .r_req(r_req), .r_addr(r_addr),
        .r_data_ready(r_data_ready), .r_rdy(r_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .r_data_axi(r_data_axi)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_cookie(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_exc(input string name, input exc_code_e got, input exc_code_e exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // memory contents seen through the refill bus
    function automatic logic [31:0] bus_word(input logic [31:0] addr);
        return addr ^ 32'hc0de_0000;
    endfunction

    function automatic logic [63:0] expected_dword(input logic [31:0] pc);
        logic [31:0] base;
        base = {pc[31:3], 3'b000};
        return {bus_word(base + 32'd4), bus_word(base)};    // lower word in low bits
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            report_failure($sformatf("timeout: no reply after %0d cycles, controller in %s",
                                     cycle, fsm_state.name()));
        end
    end

    // bus slave with random address stall and beat gaps
    initial begin : bus_model
        int          delay;
        int          gap;
        logic [31:0] base;
        r_rdy      <= 1'b0;
        ret_valid  <= 1'b0;
        ret_last   <= 1'b0;
        r_data_axi <= '0;
        forever begin
            @(posedge clk);
            if (r_req) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                r_rdy <= 1'b1;
                @(posedge clk);                 // address phase ends here
                r_rdy <= 1'b0;
                base  = r_addr;
                for (int b = 0; b < LINE_WORDS; b++) begin
                    gap = $unsigned($random(seed)) % 3;
                    ret_valid <= 1'b0;
                    ret_last  <= 1'b0;
                    repeat (gap) @(posedge clk);
                    ret_valid  <= 1'b1;
                    ret_last   <= (b == LINE_WORDS - 1);
                    r_data_axi <= bus_word(base + 32'(b * 4));
                    @(posedge clk);             // beat transfers at this edge
                    if (!r_data_ready) begin
                        report_failure("refill beat arrived while r_data_ready was low");
                    end
                end
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    end

    // one fetch from request to reply for kind 0 hit, 1 miss or 2 misaligned
    task automatic run_fetch(input logic [31:0] pc, input logic [31:0] cookie,
                             input logic [7:0] kind);
        int          lat;
        logic        saw_req;
        logic [31:0] req_addr;
        logic [63:0] exp_data;
        exc_code_e   exp_exc;
        lat      = 0;
        saw_req  = 1'b0;
        req_addr = '0;
        exp_data = (kind == 8'd2) ? 64'd0 : expected_dword(pc);
        exp_exc  = (kind == 8'd2) ? EXC_PC_MISALIGN : EXC_NONE;
        valid     <= 1'b1;
        pc_in     <= pc;
        cookie_in <= cookie;
        @(posedge clk);
        while (!ready) @(posedge clk);
        valid <= 1'b0;                          // accepted at this edge
        do begin
            @(posedge clk);
            lat++;
            if (r_req) begin
                saw_req  = 1'b1;
                req_addr = r_addr;
            end
        end while (!data_valid);
        check_addr("pc_out", pc_out, pc);
        check_cookie("cookie_out", cookie_out, cookie);
        check_exc("exception", exception, exp_exc);
        check_data("r_data", r_data, exp_data);
        if (kind == 8'd1) begin
            if (!saw_req) begin
                report_failure($sformatf("fetch of pc %h should miss but made no bus request", pc));
            end
            check_addr("r_addr", req_addr, pc & ~32'(LINE_WORDS * 4 - 1));
        end else begin
            if (saw_req) begin
                report_failure($sformatf("fetch of pc %h made an unexpected bus request", pc));
            end
            if (lat != 1) begin
                report_failure($sformatf("reply to pc %h came %0d cycles after acceptance, not 1",
                                         pc, lat));
            end
        end
    endtask

    initial begin : main
        valid     <= 1'b0;
        pc_in     <= '0;
        cookie_in <= '0;
        rst_n     <= 1'b0;
        for (int i = 0; i < MAX_PATS; i++) begin
            pat_mem[i] = '1;                    // kind ff marks unused entries
        end
        $readmemh("verif/icache_patterns.txt", pat_mem);
        num_pats = 0;
        while (num_pats < MAX_PATS && pat_mem[num_pats][7:0] != 8'hff) begin
            num_pats++;
        end
        if (num_pats == 0) begin
            report_failure("pattern file holds no fetches");
        end
        timeout_limit = RESET_CYCLES + CYCLES_PER * num_pats;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (!ready || data_valid || r_req) begin
            report_failure("cache outputs are not idle after reset");
        end
        for (int i = 0; i < num_pats; i++) begin
            run_fetch(pat_mem[i][71:40], pat_mem[i][39:8], pat_mem[i][7:0]);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/icache_patterns.txt */
// one hex word per fetch: pc (32 bits), cookie (32 bits), kind (8 bits)
// kind 00 hit, 01 miss with line refill, 02 misaligned pc
00001004_c0c00001_01
00001000_c0c00002_00
0000100c_c0c00003_00
00001008_c0c00004_00
00007006_c0c00005_02
00001002_c0c00006_02
00001008_5a5a0007_00
00010020_5a5a0008_01
00020024_5a5a0009_01
00030028_5a5a000a_01
0004002c_5a5a000b_01
00020020_5a5a000c_00
00050024_5a5a000d_01
00020028_5a5a000e_00
00010020_5a5a000f_01
0004002c_5a5a0010_00
00030024_5a5a0011_01
000000f8_0badf00d_01
000000fc_0badf00e_00
fffffff0_ffffffff_01
fffffff8_00000000_00
fffffff5_12345678_02

/* tb.f */
design/icache_pkg.sv
design/icache_fsm.sv
design/refill_buffer.sv
design/tagv_store.sv
design/data_store.sv
design/lru_select.sv
design/icache.sv
verif/icache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
